// ==== vlog.f ====
+incdir+tests
source/cf_pkg.sv
source/cf_op_if.sv
source/cf_target_if.sv
source/branch_compare.sv
source/cf_target_calc.sv
source/result_delay.sv
source/cf_ctrl.sv
source/cf_checker.sv
tests/cf_checker_tb.sv

// ==== tests/cf_model.svh ====
// ====================
// Reference next-PC rules and typed result compares for the checker testbench
// ====================

typedef struct packed {
   logic [cf_pkg::xlen-1:0]       next_pc;
   logic [cf_pkg::size_width-1:0] size;
   logic                          is_cf;
   logic                          kill;
} expected_t;

// ====================
// Reference function
function automatic expected_t reference_result(
   input logic [cf_pkg::instr_width-1:0] word,
   input logic [cf_pkg::xlen-1:0]        addr,
   input logic [cf_pkg::xlen-1:0]        a,
   input logic [cf_pkg::xlen-1:0]        b
);
   expected_t               r;
   logic [cf_pkg::xlen-1:0] imm_j;
   logic [cf_pkg::xlen-1:0] imm_i;
   logic [cf_pkg::xlen-1:0] imm_b;
   logic                    taken;

   if (word[1:0] != 2'b11) r.size = 4'd2;           // Standard length encoding
   else if (word[4:2] != 3'b111) r.size = 4'd4;
   else if (word[5] == 1'b0) r.size = 4'd6;
   else if (word[6] == 1'b0) r.size = 4'd8;
   else r.size = 4'd0;

   imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
   imm_i = {{20{word[31]}}, word[31:20]};
   imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

   case (word[14:12])
      cf_pkg::f3_beq:  taken = (a == b);
      cf_pkg::f3_bne:  taken = (a != b);
      cf_pkg::f3_blt:  taken = ($signed(a) < $signed(b));
      cf_pkg::f3_bge:  taken = ($signed(a) >= $signed(b));
      cf_pkg::f3_bltu: taken = (a < b);
      cf_pkg::f3_bgeu: taken = (a >= b);
      default:         taken = 1'b0;
   endcase

   r.next_pc = addr + r.size;                       // Fall-through unless redirected
   r.is_cf   = 1'b0;
   r.kill    = 1'b0;

   if (word[1:0] == cf_pkg::rvc_op_c1) begin
      r.kill  = (word[15:13] == cf_pkg::rvc_f3_cj) || (word[15:13] == cf_pkg::rvc_f3_cjal);
      r.is_cf = r.kill || (word[15:13] == cf_pkg::rvc_f3_cbeqz) ||
                (word[15:13] == cf_pkg::rvc_f3_cbnez);
   end else if (word[1:0] == cf_pkg::rvc_op_c2) begin
      r.kill  = ((word[15:12] == cf_pkg::rvc_f4_cjr) || (word[15:12] == cf_pkg::rvc_f4_cjalr)) &&
                (word[11:7] != 5'd0) && (word[6:2] == 5'd0);
      r.is_cf = r.kill;
   end else if (word[1:0] == 2'b11) begin
      case (word[6:0])
         cf_pkg::opc_jal: begin
            r.next_pc = addr + imm_j;
            r.is_cf   = 1'b1;
            r.kill    = 1'b1;
         end
         cf_pkg::opc_jalr: begin
            r.next_pc = (a + imm_i) & ~32'h1;       // Target bit 0 dropped
            r.is_cf   = 1'b1;
            r.kill    = 1'b1;
         end
         cf_pkg::opc_branch: begin
            if (taken) r.next_pc = addr + imm_b;
            r.is_cf = 1'b1;
            r.kill  = taken;
         end
         cf_pkg::opc_system: begin
            if (word[31:20] == cf_pkg::f12_ecall) begin
               r.next_pc = cf_pkg::ecall_target;
               r.kill    = 1'b1;
            end else if (word[31:20] == cf_pkg::f12_ebreak) begin
               r.next_pc = cf_pkg::ebreak_target;
               r.kill    = 1'b1;
            end
         end
         default: ;
      endcase
   end
   return r;
endfunction

// ====================
// Typed compares
task automatic check_pc(input string name, input logic [cf_pkg::xlen-1:0] got, want);
   checks++;
   if (got !== want) begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, want);
   end
endtask

task automatic check_size(input string name, input logic [cf_pkg::size_width-1:0] got, want);
   checks++;
   if (got !== want) begin
      errors++;
      $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, want);
   end
endtask

task automatic check_flag(input string name, input logic got, want);
   checks++;
   if (got !== want) begin
      errors++;
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, want);
   end
endtask

// ==== tests/cf_checker_tb.sv ====
// ====================
// Control-flow checker testbench: stimulus, compare process and report
// ====================
`timescale 1ns/1ps
`default_nettype none

module cf_checker_tb;

   localparam int clk_period   = 8;
   localparam int reset_cycles = 5;
   localparam int latency      = cf_pkg::result_delay + 1;   // Input register plus delay line
   localparam int idle_cycles  = 20;
   localparam int num_jump     = 16;
   localparam int num_branch   = 48;
   localparam int num_system   = 16;
   localparam int num_rvc      = 28;
   localparam int num_stream   = 200;
   localparam int num_tests    = idle_cycles + 2 * num_jump + num_branch + num_system +
                                 num_rvc + num_stream;

   typedef struct packed {
      logic [cf_pkg::instr_width-1:0] instr;
      logic [cf_pkg::xlen-1:0]        pc;
      logic [cf_pkg::xlen-1:0]        rs1;
      logic [cf_pkg::xlen-1:0]        rs2;
      int                             cycle;   // Cycle count at the strobe
   } item_t;

   logic                           clk;
   logic                           reset_;
   logic                           instr_valid;
   logic [cf_pkg::instr_width-1:0] instr;
   logic [cf_pkg::xlen-1:0]        pc;
   logic [cf_pkg::xlen-1:0]        rs1_value;
   logic [cf_pkg::xlen-1:0]        rs2_value;
   logic                           result_valid;
   logic [cf_pkg::xlen-1:0]        next_pc;
   logic [cf_pkg::size_width-1:0]  instr_size;
   logic                           is_cf;
   logic                           expects_kill;

   int     errors      = 0;
   int     checks      = 0;
   int     cycle_cnt   = 0;
   int     tests_done  = 0;
   int     test_errors = 0;
   int     test_checks = 0;
   integer seed;
   item_t  pending[$];

   `include "cf_model.svh"

   cf_checker dut_i (
      .clk          (clk),
      .reset_       (reset_),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .pc           (pc),
      .rs1_value    (rs1_value),
      .rs2_value    (rs2_value),
      .result_valid (result_valid),
      .next_pc      (next_pc),
      .instr_size   (instr_size),
      .is_cf        (is_cf),
      .expects_kill (expects_kill)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // ====================
   // Stimulus helpers
   function automatic logic [cf_pkg::xlen-1:0] random_pc();
      logic [cf_pkg::xlen-1:0] r;
      r = $random(seed);
      return {r[cf_pkg::xlen-1:1], 1'b0};              // Halfword aligned
   endfunction

   task automatic drive_instr(input logic [cf_pkg::instr_width-1:0] word,
                              input logic [cf_pkg::xlen-1:0] addr, a, b);
      @(posedge clk);
      #1;
      instr_valid = 1'b1;
      instr       = word;
      pc          = addr;
      rs1_value   = a;
      rs2_value   = b;
      pending.push_back('{word, addr, a, b, cycle_cnt});
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
   endtask

   task automatic finish_test(input string name);
      while (pending.size() != 0) @(posedge clk);     // Drain results in flight
      tests_done++;
      $display("test %-12s %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   // ====================
   // Compare process
   always @(negedge clk) begin : compare
      item_t     item;
      expected_t ref_res;
      if (result_valid === 1'b1) begin
         if (pending.size() == 0) begin
            errors++;
            $display("ERROR t=%0t result came out with no instruction pending", $time);
         end else begin
            item    = pending.pop_front();
            ref_res = reference_result(item.instr, item.pc, item.rs1, item.rs2);
            checks++;
            if (cycle_cnt - item.cycle != latency) begin
               errors++;
               $display("ERROR t=%0t result arrived %0d cycles after its strobe, not %0d",
                        $time, cycle_cnt - item.cycle, latency);
            end
            check_pc("next_pc", next_pc, ref_res.next_pc);
            check_size("instr_size", instr_size, ref_res.size);
            check_flag("is_cf", is_cf, ref_res.is_cf);
            check_flag("expects_kill", expects_kill, ref_res.kill);
         end
      end
   end

   // ====================
   // Test sequence
   initial begin : stimulus
      logic [cf_pkg::instr_width-1:0] word;
      logic [cf_pkg::xlen-1:0]        a;
      logic [cf_pkg::xlen-1:0]        b;
      reset_      = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      pc          = '0;
      rs1_value   = '0;
      rs2_value   = '0;
      seed        = 30747;
      repeat (reset_cycles) @(posedge clk);
      #1 reset_ = 1'b1;

      repeat (idle_cycles) begin                       // Outputs stay quiet with no strobe
         @(negedge clk);
         check_flag("result_valid", result_valid, 1'b0);
         check_flag("is_cf", is_cf, 1'b0);
         check_flag("expects_kill", expects_kill, 1'b0);
      end
      finish_test("reset_idle");

      for (int k = 0; k < 2 * num_jump; k++) begin
         word      = $random(seed);
         word[6:0] = (k % 2) ? cf_pkg::opc_jalr : cf_pkg::opc_jal;
         a         = $random(seed);
         b         = $random(seed);
         drive_instr(word, random_pc(), a, b);
         idle_cycle();
      end
      finish_test("jal_jalr");

      for (int k = 0; k < num_branch; k++) begin
         word        = $random(seed);
         word[6:0]   = cf_pkg::opc_branch;
         word[14:12] = (k % 6 < 2) ? k % 6 : k % 6 + 2;  // Skip codes 010 and 011
         a           = $random(seed);
         b           = $random(seed);
         case ((k / 6) % 4)
            1: b = a;
            2: begin a = 32'h8000_0000; b = 32'h7fff_ffff; end  // Signed less, unsigned greater
            3: begin a = 32'h0000_0001; b = 32'hffff_ffff; end
            default: ;
         endcase
         drive_instr(word, random_pc(), a, b);
         idle_cycle();
      end
      finish_test("branch");

      for (int k = 0; k < num_system; k++) begin
         word = $random(seed);
         case (k % 8)
            0: word = 32'h0000_0073;                   // ecall
            1: word = 32'h0010_0073;                   // ebreak
            2: word[6:0] = 7'b0010011;
            3: word[6:0] = 7'b0110011;
            4: word[6:0] = 7'b0110111;
            5: word[6:0] = 7'b0010111;
            6: word[6:0] = 7'b0000011;
            default: word[6:0] = 7'b0100011;
         endcase
         drive_instr(word, random_pc(), $random(seed), $random(seed));
         idle_cycle();
      end
      finish_test("system_alu");

      for (int k = 0; k < num_rvc; k++) begin
         word = $random(seed);
         case (k % 7)
            0: word[15:0] = {3'b101, word[12:2], 2'b01};            // c.j
            1: word[15:0] = {3'b001, word[12:2], 2'b01};            // c.jal
            2: word[15:0] = {3'b110, word[12:2], 2'b01};            // c.beqz
            3: word[15:0] = {3'b111, word[12:2], 2'b01};            // c.bnez
            4: word[15:0] = {4'b1000, word[11:8], 1'b1, 7'b0000010}; // c.jr
            5: word[15:0] = {4'b1001, word[11:8], 1'b1, 7'b0000010}; // c.jalr
            default: word[6:0] = ((k / 7) % 2) ? 7'b0111111 : {word[6], 6'b011111};
         endcase
         drive_instr(word, random_pc(), $random(seed), $random(seed));
         idle_cycle();
      end
      finish_test("compressed");

      for (int k = 0; k < num_stream; k++) begin       // One strobe per cycle
         word = $random(seed);
         a    = $random(seed);
         b    = word[21] ? a : $random(seed);
         case (k % 8)
            0: word[6:0] = cf_pkg::opc_branch;
            1: word[6:0] = cf_pkg::opc_jal;
            2: word[6:0] = cf_pkg::opc_jalr;
            3: word = word[20] ? 32'h0010_0073 : 32'h0000_0073;
            default: ;
         endcase
         drive_instr(word, random_pc(), a, b);
      end
      idle_cycle();
      finish_test("stream");

      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // ====================
   // Watchdog
   initial begin
      #(num_tests * clk_period * 4 + reset_cycles * clk_period);
      $display("ERROR t=%0t watchdog expired before all results came back", $time);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/cf_checker.sv ====
// ====================
// Control-flow reference checker top: control, datapath and delay line
// ====================
`timescale 1ns/1ps
`default_nettype none

module cf_checker (
   input  wire                                clk,
   input  wire                                reset_,
   input  wire                                instr_valid,
   input  wire  [cf_pkg::instr_width-1:0]     instr,
   input  wire  [cf_pkg::xlen-1:0]            pc,
   input  wire  [cf_pkg::xlen-1:0]            rs1_value,
   input  wire  [cf_pkg::xlen-1:0]            rs2_value,
   output logic                               result_valid,
   output logic [cf_pkg::xlen-1:0]            next_pc,
   output logic [cf_pkg::size_width-1:0]      instr_size,
   output logic                               is_cf,
   output logic                               expects_kill
);

   logic                              branch_taken;
   logic [cf_pkg::result_width-1:0]   ctrl_result;
   logic [cf_pkg::result_width-1:0]   delayed_result;

   cf_op_if     op_if ();
   cf_target_if tgt_if ();

   cf_ctrl ctrl_i (
      .clk          (clk),
      .reset_       (reset_),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .pc           (pc),
      .rs1_value    (rs1_value),
      .rs2_value    (rs2_value),
      .op           (op_if.source),
      .tgt          (tgt_if.sink),
      .branch_taken (branch_taken),
      .result       (ctrl_result)
   );

   cf_target_calc target_calc_i (
      .op  (op_if.sink),
      .tgt (tgt_if.source)
   );

   branch_compare branch_compare_i (
      .op           (op_if.sink),
      .branch_taken (branch_taken)
   );

   result_delay #(
      .delay_amount (cf_pkg::result_delay),
      .width        (cf_pkg::result_width)
   ) result_delay_i (
      .clk      (clk),
      .reset_   (reset_),
      .in_word  (ctrl_result),
      .out_word (delayed_result)
   );

   // {valid, next_pc, size, is_cf, expects_kill}
   assign result_valid = delayed_result[cf_pkg::result_width-1];
   assign next_pc      = delayed_result[cf_pkg::xlen+cf_pkg::size_width+1:cf_pkg::size_width+2];
   assign instr_size   = delayed_result[cf_pkg::size_width+1:2];
   assign is_cf        = delayed_result[1];
   assign expects_kill = delayed_result[0];

endmodule

`default_nettype wire

// ==== source/cf_ctrl.sv ====
// ====================
// Checker control: registers the entry, decodes class and length,
// picks the correct next PC and forms the flags
// ====================
`timescale 1ns/1ps
`default_nettype none

module cf_ctrl (
   input  wire                               clk,
   input  wire                               reset_,
   input  wire                               instr_valid,
   input  wire  [cf_pkg::instr_width-1:0]    instr,
   input  wire  [cf_pkg::xlen-1:0]           pc,
   input  wire  [cf_pkg::xlen-1:0]           rs1_value,
   input  wire  [cf_pkg::xlen-1:0]           rs2_value,
   cf_op_if.source                           op,
   cf_target_if.sink                         tgt,
   input  wire                               branch_taken,
   output logic [cf_pkg::result_width-1:0]   result
);

   logic                            entry_valid;
   cf_pkg::instr_word_u             entry_word;
   logic [cf_pkg::xlen-1:0]         entry_pc;
   logic [cf_pkg::xlen-1:0]         entry_rs1;
   logic [cf_pkg::xlen-1:0]         entry_rs2;
   logic [cf_pkg::size_width-1:0]   entry_size;
   logic [11:0]                     funct12;
   logic [3:0]                      rvc_funct4;
   logic                            is_rvc;
   logic                            rv32_branch, rv32_jal, rv32_jalr;
   logic                            rvc_branch, rvc_jal, rvc_jalr;
   logic                            is_ecall, is_ebreak;
   logic                            is_cf, expects_kill;
   logic [cf_pkg::xlen-1:0]         next_pc;

   // ====================
   // Entry register
   always_ff @(posedge clk) begin
      if (!reset_)
         entry_valid <= 1'b0;
      else
         entry_valid <= instr_valid;
   end

   always_ff @(posedge clk) begin
      if (instr_valid) begin                  // Payload only, no reset
         entry_word <= instr;
         entry_pc   <= pc;
         entry_rs1  <= rs1_value;
         entry_rs2  <= rs2_value;
      end
   end

   always_comb begin
      casez (entry_word.rv32.opcode)
         7'b?????00, 7'b?????01, 7'b?????10: entry_size = 4'd2;
         7'b????011, 7'b???0?11, 7'b??0??11: entry_size = 4'd4;
         7'b?011111:                         entry_size = 4'd6;
         7'b0111111:                         entry_size = 4'd8;
         default:                            entry_size = 4'd0;  // Reserved long forms
      endcase
   end

   assign op.word      = entry_word;
   assign op.pc        = entry_pc;
   assign op.rs1_value = entry_rs1;
   assign op.rs2_value = entry_rs2;
   assign op.size      = entry_size;

   // ====================
   // Classification
   assign is_rvc     = (entry_word.rvc.quadrant != 2'b11);
   assign funct12    = {entry_word.rv32.funct7, entry_word.rv32.rs2};
   assign rvc_funct4 = {entry_word.rvc.funct3, entry_word.rvc.funct4_lsb};

   assign rv32_branch = !is_rvc && (entry_word.rv32.opcode == cf_pkg::opc_branch);
   assign rv32_jal    = !is_rvc && (entry_word.rv32.opcode == cf_pkg::opc_jal);
   assign rv32_jalr   = !is_rvc && (entry_word.rv32.opcode == cf_pkg::opc_jalr);
   assign is_ecall    = !is_rvc && (entry_word.rv32.opcode == cf_pkg::opc_system) &&
                        (funct12 == cf_pkg::f12_ecall);
   assign is_ebreak   = !is_rvc && (entry_word.rv32.opcode == cf_pkg::opc_system) &&
                        (funct12 == cf_pkg::f12_ebreak);

   assign rvc_branch = is_rvc && (entry_word.rvc.quadrant == cf_pkg::rvc_op_c1) &&
                       ((entry_word.rvc.funct3 == cf_pkg::rvc_f3_cbeqz) ||
                        (entry_word.rvc.funct3 == cf_pkg::rvc_f3_cbnez));
   assign rvc_jal    = is_rvc && (entry_word.rvc.quadrant == cf_pkg::rvc_op_c1) &&
                       ((entry_word.rvc.funct3 == cf_pkg::rvc_f3_cj) ||
                        (entry_word.rvc.funct3 == cf_pkg::rvc_f3_cjal));
   assign rvc_jalr   = is_rvc && (entry_word.rvc.quadrant == cf_pkg::rvc_op_c2) &&
                       (entry_word.rvc.rs1 != 5'd0) && (entry_word.rvc.rs2 == 5'd0) &&
                       ((rvc_funct4 == cf_pkg::rvc_f4_cjr) ||
                        (rvc_funct4 == cf_pkg::rvc_f4_cjalr));

   // ====================
   // Next PC and flags
   always_comb begin
      if (is_rvc)
         next_pc = tgt.seq_pc;                // Compressed targets not computed
      else if (rv32_jal)
         next_pc = tgt.jal_target;
      else if (rv32_jalr)
         next_pc = tgt.jalr_target;
      else if (rv32_branch)
         next_pc = branch_taken ? tgt.branch_target : tgt.seq_pc;
      else if (is_ecall)
         next_pc = cf_pkg::ecall_target;
      else if (is_ebreak)
         next_pc = cf_pkg::ebreak_target;
      else
         next_pc = tgt.seq_pc;
   end

   assign is_cf        = entry_valid && (rv32_branch || rv32_jal || rv32_jalr ||
                                         rvc_branch || rvc_jal || rvc_jalr);
   assign expects_kill = entry_valid && (rv32_jal || rv32_jalr || rvc_jal || rvc_jalr ||
                                         (rv32_branch && branch_taken) ||
                                         is_ecall || is_ebreak);

   assign result = {entry_valid, next_pc, entry_size, is_cf, expects_kill};

   // 32-bit op must never leave an odd next PC, whatever unit produced it
   a_next_pc_aligned : assert property (@(posedge clk) disable iff (!reset_)
      (entry_valid && !is_rvc && (entry_size == 4'd4)) |-> !next_pc[0]);

endmodule

`default_nettype wire

// ==== source/result_delay.sv ====
// ====================
// Fixed-latency delay line for the result word, cleared on reset
// ====================
`timescale 1ns/1ps
`default_nettype none

module result_delay #(
   parameter int delay_amount = 1,              // Must be at least 1
   parameter int width        = 1
) (
   input  wire                clk,
   input  wire                reset_,
   input  wire  [width-1:0]   in_word,
   output logic [width-1:0]   out_word
);

   logic [delay_amount-1:0][width-1:0] stage;

   always_ff @(posedge clk) begin
      if (!reset_) begin
         stage <= '0;                           // Drains valid and flags
      end else begin
         stage[0] <= in_word;
         for (int i = 1; i < delay_amount; i++) begin
            stage[i] <= stage[i-1];
         end
      end
   end

   assign out_word = stage[delay_amount-1];

   // Msb carries the valid flag
   a_valid_latency : assert property (@(posedge clk) disable iff (!reset_)
      in_word[width-1] |-> ##delay_amount out_word[width-1]);

endmodule

`default_nettype wire

// ==== source/cf_target_calc.sv ====
// ====================
// Immediate extraction and jump, branch and fall-through target adders
// ====================
`timescale 1ns/1ps
`default_nettype none

module cf_target_calc (
   cf_op_if.sink        op,
   cf_target_if.source  tgt
);

   logic [cf_pkg::xlen-1:0] imm_j;
   logic [cf_pkg::xlen-1:0] imm_i;
   logic [cf_pkg::xlen-1:0] imm_b;
   logic [cf_pkg::xlen-1:0] jalr_sum;
   logic [cf_pkg::xlen-1:0] seq_inc;

   // J-type: imm[20|10:1|11|19:12]
   assign imm_j = {{(cf_pkg::xlen-20){op.word.rv32.funct7[6]}},
                   op.word.rv32.rs1, op.word.rv32.funct3,        // imm[19:12]
                   op.word.rv32.rs2[0],                           // imm[11]
                   op.word.rv32.funct7[5:0], op.word.rv32.rs2[4:1], // imm[10:1]
                   1'b0};

   // I-type: imm[11:0] sits in funct12
   assign imm_i = {{(cf_pkg::xlen-12){op.word.rv32.funct7[6]}},
                   op.word.rv32.funct7, op.word.rv32.rs2};

   // B-type: imm[12|10:5] and imm[4:1|11]
   assign imm_b = {{(cf_pkg::xlen-12){op.word.rv32.funct7[6]}},
                   op.word.rv32.rd[0],                            // imm[11]
                   op.word.rv32.funct7[5:0],                      // imm[10:5]
                   op.word.rv32.rd[4:1],                          // imm[4:1]
                   1'b0};

   assign seq_inc  = {{(cf_pkg::xlen-cf_pkg::size_width){1'b0}}, op.size};
   assign jalr_sum = op.rs1_value + imm_i;

   assign tgt.jal_target    = op.pc + imm_j;
   assign tgt.jalr_target   = {jalr_sum[cf_pkg::xlen-1:1], 1'b0};  // Spec clears bit 0
   assign tgt.branch_target = op.pc + imm_b;
   assign tgt.seq_pc        = op.pc + seq_inc;

endmodule

`default_nettype wire

// ==== source/branch_compare.sv ====
// ====================
// Branch condition from funct3 and the operand values
// ====================
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
   cf_op_if.sink  op,
   output logic   branch_taken
);

   always_comb begin
      case (op.word.rv32.funct3)
         cf_pkg::f3_beq:
            branch_taken = (op.rs1_value == op.rs2_value);
         cf_pkg::f3_bne:
            branch_taken = (op.rs1_value != op.rs2_value);
         cf_pkg::f3_blt:
            branch_taken = ($signed(op.rs1_value) <  $signed(op.rs2_value));
         cf_pkg::f3_bge:
            branch_taken = ($signed(op.rs1_value) >= $signed(op.rs2_value));
         cf_pkg::f3_bltu:
            branch_taken = (op.rs1_value <  op.rs2_value);
         cf_pkg::f3_bgeu:
            branch_taken = (op.rs1_value >= op.rs2_value);
         default:
            branch_taken = 1'b0;                // 010 and 011 are not branches
      endcase
   end

endmodule

`default_nettype wire

// ==== source/cf_target_if.sv ====
// ====================
// Candidate next-PC values returned to control
// ====================
`timescale 1ns/1ps
`default_nettype none

interface cf_target_if;

   logic [cf_pkg::xlen-1:0] jal_target;
   logic [cf_pkg::xlen-1:0] jalr_target;     // Bit 0 already cleared
   logic [cf_pkg::xlen-1:0] branch_target;
   logic [cf_pkg::xlen-1:0] seq_pc;          // Fall-through address

   modport source (
      output jal_target, jalr_target, branch_target, seq_pc
   );

   modport sink (
      input jal_target, jalr_target, branch_target, seq_pc
   );

endinterface

`default_nettype wire

// ==== source/cf_op_if.sv ====
// ====================
// Registered instruction entry from control to the datapath units
// ====================
`timescale 1ns/1ps
`default_nettype none

interface cf_op_if;

   cf_pkg::instr_word_u             word;
   logic [cf_pkg::xlen-1:0]         pc;
   logic [cf_pkg::xlen-1:0]         rs1_value;
   logic [cf_pkg::xlen-1:0]         rs2_value;
   logic [cf_pkg::size_width-1:0]   size;         // Decoded length in bytes

   modport source (
      output word, pc, rs1_value, rs2_value, size
   );

   modport sink (
      input word, pc, rs1_value, rs2_value, size
   );

endinterface

`default_nettype wire

// ==== source/cf_pkg.sv ====
// ====================
// Control-flow checker shared widths, ISA codes and instruction word views
// ====================
`default_nettype none

package cf_pkg;

   // ====================
   // Widths and latency
   localparam int instr_width  = 32;
   localparam int xlen         = 32;
   localparam int size_width   = 4;                   // Length in bytes, up to 8
   localparam int result_delay = 2;
   localparam int result_width = 1 + xlen + size_width + 2; // valid, pc, size, two flags

   // ====================
   // RV32 encodings
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_system = 7'b1110011;

   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   localparam logic [11:0] f12_ecall  = 12'h000;
   localparam logic [11:0] f12_ebreak = 12'h001;

   localparam logic [xlen-1:0] ecall_target  = 32'h0000_0800; // Trap vectors
   localparam logic [xlen-1:0] ebreak_target = 32'h0000_0c00;

   // ====================
   // Compressed encodings
   localparam logic [1:0] rvc_op_c1 = 2'b01;
   localparam logic [1:0] rvc_op_c2 = 2'b10;

   localparam logic [2:0] rvc_f3_cj    = 3'b101;
   localparam logic [2:0] rvc_f3_cjal  = 3'b001;
   localparam logic [2:0] rvc_f3_cbeqz = 3'b110;
   localparam logic [2:0] rvc_f3_cbnez = 3'b111;

   localparam logic [3:0] rvc_f4_cjr   = 4'b1000;
   localparam logic [3:0] rvc_f4_cjalr = 4'b1001;

   typedef struct packed {
      logic [6:0] funct7;                             // Upper half of funct12
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv32_view_t;

   typedef struct packed {
      logic [15:0] upper;                             // Next parcel, not part of a 16-bit op
      logic [2:0]  funct3;
      logic        funct4_lsb;                        // funct4 is {funct3, funct4_lsb}
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [1:0]  quadrant;
   } rvc_view_t;

   typedef union packed {
      rv32_view_t rv32;
      rvc_view_t  rvc;
   } instr_word_u;

endpackage

`default_nettype wire
